// File: pwm_pkg.sv
// ================================================
// PWM controller package
// Widths, channel counts and register word indices
// ================================================
`default_nettype none

package pwm_pkg;

  // Bus and timing register width
  localparam int DATA_W = 16;
  localparam int ADDR_W = 8;

  // Channel counts
  localparam int PWM_NUM  = 4;
  localparam int TACH_NUM = 2;

  // Tach prescale code and tick divider widths
  localparam int TACH_PRE_W = 4;
  localparam int TACH_DIV_W = 11;

  // Word indices, taken from PADDR[7:2]
  localparam logic [ADDR_W-3:0] REG_PRESCALE     = 6'h00;
  localparam logic [ADDR_W-3:0] REG_PERIOD       = 6'h01;
  localparam logic [ADDR_W-3:0] REG_ENABLE       = 6'h02;

  // Channel n rising edge at base + 2n, falling edge right after it
  localparam logic [ADDR_W-3:0] REG_POSEDGE_BASE = 6'h04;
  localparam logic [ADDR_W-3:0] REG_NEGEDGE_BASE = 6'h05;

  localparam logic [ADDR_W-3:0] REG_TACHPRESCALE = 6'h25;
  localparam logic [ADDR_W-3:0] REG_TACHSTATUS   = 6'h26;
  localparam logic [ADDR_W-3:0] REG_TACHIRQMASK  = 6'h27;
  localparam logic [ADDR_W-3:0] REG_TACHMODE     = 6'h28;

  // Input t duration at base + t
  localparam logic [ADDR_W-3:0] REG_TACHDUR_BASE = 6'h29;

endpackage

`default_nettype wire

// File: pwm_apb_regs.sv
// ================================================
// PWM register file
// APB decode, configuration registers, read mux
// ================================================
`timescale 1ns/1ps
`default_nettype none

module pwm_apb_regs
  import pwm_pkg::*;
(
  input  logic                             PCLK,
  input  logic                             PRESETN,
  input  logic                             PSEL,
  input  logic                             PENABLE,
  input  logic                             PWRITE,
  input  logic [ADDR_W-1:0]                PADDR,
  input  logic [DATA_W-1:0]                PWDATA,
  output logic [DATA_W-1:0]                PRDATA,
  output logic [DATA_W-1:0]                prescale,
  output logic [DATA_W-1:0]                period,
  output logic [PWM_NUM-1:0]               pwm_enable,
  output logic [PWM_NUM-1:0][DATA_W-1:0]   pwm_posedge,
  output logic [PWM_NUM-1:0][DATA_W-1:0]   pwm_negedge,
  output logic [TACH_PRE_W-1:0]            tach_prescale,
  output logic [TACH_NUM-1:0]              tach_irq_mask,
  output logic [TACH_NUM-1:0]              tach_mode,
  output logic [TACH_NUM-1:0]              status_clear,
  input  logic [TACH_NUM-1:0]              tach_status,
  input  logic [TACH_NUM-1:0][DATA_W-1:0]  tach_dur
);

  logic [ADDR_W-3:0] word_idx;
  logic              wr_en;

  assign word_idx = PADDR[ADDR_W-1:2];
  assign wr_en    = PSEL & PENABLE & PWRITE;

  // Write 1 to clear, one cycle wide
  assign status_clear = (wr_en && (word_idx == REG_TACHSTATUS)) ?
                        PWDATA[TACH_NUM-1:0] : '0;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      prescale      <= '0;
      period        <= '0;
      pwm_enable    <= '0;
      pwm_posedge   <= '0;
      pwm_negedge   <= '0;
      tach_prescale <= '0;
      tach_irq_mask <= '0;
      tach_mode     <= '0;
    end
    else if (wr_en)
    begin
      case (word_idx)
        REG_PRESCALE:     prescale      <= PWDATA;
        REG_PERIOD:       period        <= PWDATA;
        REG_ENABLE:       pwm_enable    <= PWDATA[PWM_NUM-1:0];
        REG_TACHPRESCALE: tach_prescale <= PWDATA[TACH_PRE_W-1:0];
        REG_TACHIRQMASK:  tach_irq_mask <= PWDATA[TACH_NUM-1:0];
        REG_TACHMODE:     tach_mode     <= PWDATA[TACH_NUM-1:0];
        default:
        begin
          // Edge registers, interleaved per channel
          for (int n = 0; n < PWM_NUM; n++)
          begin
            if (int'(word_idx) == int'(REG_POSEDGE_BASE) + 2 * n)
              pwm_posedge[n] <= PWDATA;
            if (int'(word_idx) == int'(REG_NEGEDGE_BASE) + 2 * n)
              pwm_negedge[n] <= PWDATA;
          end
        end
      endcase
    end
  end

  always_comb
  begin
    PRDATA = '0;
    case (word_idx)
      REG_PRESCALE:     PRDATA = prescale;
      REG_PERIOD:       PRDATA = period;
      REG_ENABLE:       PRDATA[PWM_NUM-1:0] = pwm_enable;
      REG_TACHPRESCALE: PRDATA[TACH_PRE_W-1:0] = tach_prescale;
      REG_TACHSTATUS:   PRDATA[TACH_NUM-1:0] = tach_status;
      REG_TACHIRQMASK:  PRDATA[TACH_NUM-1:0] = tach_irq_mask;
      REG_TACHMODE:     PRDATA[TACH_NUM-1:0] = tach_mode;
      default:
      begin
        for (int n = 0; n < PWM_NUM; n++)
        begin
          if (int'(word_idx) == int'(REG_POSEDGE_BASE) + 2 * n)
            PRDATA = pwm_posedge[n];
          if (int'(word_idx) == int'(REG_NEGEDGE_BASE) + 2 * n)
            PRDATA = pwm_negedge[n];
        end
        // Measured durations, read only
        for (int t = 0; t < TACH_NUM; t++)
        begin
          if (int'(word_idx) == int'(REG_TACHDUR_BASE) + t)
            PRDATA = tach_dur[t];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: pwm_timebase.sv
// ================================================
// PWM timebase
// Prescale divider and period position counter
// ================================================
`timescale 1ns/1ps
`default_nettype none

module pwm_timebase
  import pwm_pkg::*;
(
  input  logic              PCLK,
  input  logic              PRESETN,
  input  logic [DATA_W-1:0] prescale,
  input  logic [DATA_W-1:0] period,
  output logic [DATA_W-1:0] period_cnt,
  output logic              sync_pulse
);

  logic [DATA_W-1:0] pre_cnt;
  logic              tick;
  logic              wrap;

  // Compare with >= so a smaller new value takes effect at once
  assign tick = (pre_cnt >= prescale);
  assign wrap = tick && (period_cnt >= period);

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      pre_cnt    <= '0;
      period_cnt <= '0;
      sync_pulse <= 1'b0;
    end
    else
    begin
      if (tick)
        pre_cnt <= '0;
      else
        pre_cnt <= pre_cnt + 1'b1;

      if (wrap)
        period_cnt <= '0;
      else if (tick)
        period_cnt <= period_cnt + 1'b1;

      // High in the first cycle of each period
      sync_pulse <= wrap;
    end
  end

endmodule

`default_nettype wire

// File: pwm_channels.sv
// ================================================
// PWM channel outputs
// Compare window per channel, registered outputs
// ================================================
`timescale 1ns/1ps
`default_nettype none

module pwm_channels
  import pwm_pkg::*;
(
  input  logic                           PCLK,
  input  logic                           PRESETN,
  input  logic [DATA_W-1:0]              period_cnt,
  input  logic [PWM_NUM-1:0]             pwm_enable,
  input  logic [PWM_NUM-1:0][DATA_W-1:0] pwm_posedge,
  input  logic [PWM_NUM-1:0][DATA_W-1:0] pwm_negedge,
  output logic [PWM_NUM-1:0]             PWM
);

  logic [PWM_NUM-1:0] in_window;

  always_comb
  begin
    for (int n = 0; n < PWM_NUM; n++)
    begin
      if (pwm_posedge[n] < pwm_negedge[n])
      begin
        in_window[n] = (period_cnt >= pwm_posedge[n]) &&
                       (period_cnt < pwm_negedge[n]);
      end
      else if (pwm_posedge[n] > pwm_negedge[n])
      begin
        // Window wraps through the end of the period
        in_window[n] = (period_cnt >= pwm_posedge[n]) ||
                       (period_cnt < pwm_negedge[n]);
      end
      else
      begin
        in_window[n] = 1'b0;
      end
    end
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
      PWM <= '0;
    else
      PWM <= pwm_enable & in_window;
  end

endmodule

`default_nettype wire

// File: tach_capture.sv
// ================================================
// Tach capture
// Sync, rising edge detect and tick count of one input
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tach_capture
  import pwm_pkg::*;
(
  input  logic              PCLK,
  input  logic              PRESETN,
  input  logic              tach_in,
  input  logic              tach_tick,
  input  logic              accept,
  output logic [DATA_W-1:0] tach_dur,
  output logic              update
);

  logic [1:0]        sync_q;
  logic              prev_q;
  logic              armed;
  logic              rise;
  logic [DATA_W-1:0] tick_cnt;

  assign rise = sync_q[1] & ~prev_q;

  // No duration until a first edge has started the count
  assign update = rise & armed;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      sync_q   <= '0;
      prev_q   <= 1'b0;
      armed    <= 1'b0;
      tick_cnt <= '0;
      tach_dur <= '0;
    end
    else
    begin
      sync_q <= {sync_q[0], tach_in};
      prev_q <= sync_q[1];

      if (rise)
      begin
        armed    <= 1'b1;
        tick_cnt <= '0;
      end
      else if (tach_tick && (tick_cnt != '1))
      begin
        // Saturates on a stalled fan
        tick_cnt <= tick_cnt + 1'b1;
      end

      if (update && accept)
        tach_dur <= tick_cnt;
    end
  end

endmodule

`default_nettype wire

// File: tach_block.sv
// ================================================
// Tach block
// Shared tick, capture per input, status and interrupt
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tach_block
  import pwm_pkg::*;
(
  input  logic                            PCLK,
  input  logic                            PRESETN,
  input  logic [TACH_NUM-1:0]             TACHIN,
  input  logic [TACH_PRE_W-1:0]           tach_prescale,
  input  logic [TACH_NUM-1:0]             tach_irq_mask,
  input  logic [TACH_NUM-1:0]             tach_mode,
  input  logic [TACH_NUM-1:0]             status_clear,
  output logic [TACH_NUM-1:0]             tach_status,
  output logic [TACH_NUM-1:0][DATA_W-1:0] tach_dur,
  output logic                            TACHINT
);

  logic [TACH_DIV_W-1:0] div_val;
  logic [TACH_DIV_W-1:0] div_cnt;
  logic                  tach_tick;
  logic [TACH_NUM-1:0]   update;
  logic [TACH_NUM-1:0]   accept;

  // 2^code - 1, code limited to 11
  always_comb
  begin
    if (tach_prescale >= TACH_PRE_W'(TACH_DIV_W))
      div_val = '1;
    else
      div_val = TACH_DIV_W'((1 << tach_prescale) - 1);
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      div_cnt   <= '0;
      tach_tick <= 1'b0;
    end
    else if (div_cnt >= div_val)
    begin
      div_cnt   <= '0;
      tach_tick <= 1'b1;
    end
    else
    begin
      div_cnt   <= div_cnt + 1'b1;
      tach_tick <= 1'b0;
    end
  end

  // One-shot inputs hold their value while status is set
  assign accept = ~tach_mode | ~tach_status;

  for (genvar t = 0; t < TACH_NUM; t++)
  begin : g_tach
    tach_capture u_capture (
      .PCLK      (PCLK),
      .PRESETN   (PRESETN),
      .tach_in   (TACHIN[t]),
      .tach_tick (tach_tick),
      .accept    (accept[t]),
      .tach_dur  (tach_dur[t]),
      .update    (update[t])
    );
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      tach_status <= '0;
      TACHINT     <= 1'b0;
    end
    else
    begin
      // Clear wins over a new update
      tach_status <= (tach_status | (update & accept)) & ~status_clear;
      TACHINT     <= |(tach_status & tach_irq_mask);
    end
  end

endmodule

`default_nettype wire

// File: pwm_core.sv
// ================================================
// PWM controller top
// APB register file, timebase, PWM channels, tach
// ================================================
`timescale 1ns/1ps
`default_nettype none

module pwm_core
  import pwm_pkg::*;
(
  input  logic                PCLK,
  input  logic                PRESETN,
  input  logic                PSEL,
  input  logic                PENABLE,
  input  logic                PWRITE,
  input  logic [ADDR_W-1:0]   PADDR,
  input  logic [DATA_W-1:0]   PWDATA,
  output logic [DATA_W-1:0]   PRDATA,
  output logic                PREADY,
  output logic                PSLVERR,
  input  logic [TACH_NUM-1:0] TACHIN,
  output logic                TACHINT,
  output logic [PWM_NUM-1:0]  PWM
);

  logic [DATA_W-1:0]              prescale;
  logic [DATA_W-1:0]              period;
  logic [PWM_NUM-1:0]             pwm_enable;
  logic [PWM_NUM-1:0][DATA_W-1:0] pwm_posedge;
  logic [PWM_NUM-1:0][DATA_W-1:0] pwm_negedge;
  logic [DATA_W-1:0]              period_cnt;
  // Period start marker, also watched by the testbench
  logic                           sync_pulse;

  logic [TACH_PRE_W-1:0]            tach_prescale;
  logic [TACH_NUM-1:0]              tach_irq_mask;
  logic [TACH_NUM-1:0]              tach_mode;
  logic [TACH_NUM-1:0]              status_clear;
  logic [TACH_NUM-1:0]              tach_status;
  logic [TACH_NUM-1:0][DATA_W-1:0]  tach_dur;

  // Zero wait state, never an error
  assign PREADY  = 1'b1;
  assign PSLVERR = 1'b0;

  pwm_apb_regs u_regs (
    .PCLK          (PCLK),
    .PRESETN       (PRESETN),
    .PSEL          (PSEL),
    .PENABLE       (PENABLE),
    .PWRITE        (PWRITE),
    .PADDR         (PADDR),
    .PWDATA        (PWDATA),
    .PRDATA        (PRDATA),
    .prescale      (prescale),
    .period        (period),
    .pwm_enable    (pwm_enable),
    .pwm_posedge   (pwm_posedge),
    .pwm_negedge   (pwm_negedge),
    .tach_prescale (tach_prescale),
    .tach_irq_mask (tach_irq_mask),
    .tach_mode     (tach_mode),
    .status_clear  (status_clear),
    .tach_status   (tach_status),
    .tach_dur      (tach_dur)
  );

  pwm_timebase u_timebase (
    .PCLK       (PCLK),
    .PRESETN    (PRESETN),
    .prescale   (prescale),
    .period     (period),
    .period_cnt (period_cnt),
    .sync_pulse (sync_pulse)
  );

  pwm_channels u_channels (
    .PCLK        (PCLK),
    .PRESETN     (PRESETN),
    .period_cnt  (period_cnt),
    .pwm_enable  (pwm_enable),
    .pwm_posedge (pwm_posedge),
    .pwm_negedge (pwm_negedge),
    .PWM         (PWM)
  );

  tach_block u_tach (
    .PCLK          (PCLK),
    .PRESETN       (PRESETN),
    .TACHIN        (TACHIN),
    .tach_prescale (tach_prescale),
    .tach_irq_mask (tach_irq_mask),
    .tach_mode     (tach_mode),
    .status_clear  (status_clear),
    .tach_status   (tach_status),
    .tach_dur      (tach_dur),
    .TACHINT       (TACHINT)
  );

endmodule

`default_nettype wire

// File: pwm_checker.sv
// ================================================
// PWM controller checker
// Compares bus responses, PWM and TACHINT with expected values
// ================================================
`timescale 1ns/1ps
`default_nettype none

module pwm_checker
  import pwm_pkg::*;
(
  input  logic               PCLK,
  input  logic               req,
  input  logic [3:0]         op,
  input  logic [DATA_W-1:0]  sel,
  input  logic [DATA_W-1:0]  expv,
  input  logic [DATA_W-1:0]  tol,
  input  logic [DATA_W-1:0]  PRDATA,
  input  logic               PREADY,
  input  logic               PSLVERR,
  input  logic [PWM_NUM-1:0] PWM,
  input  logic               TACHINT,
  input  logic               sync_pulse,
  output int                 done_cnt,
  output int                 test_cnt,
  output int                 err_cnt
);

  localparam logic [3:0] OP_READ = 4'h2;
  localparam logic [3:0] OP_PWM  = 4'h3;
  localparam logic [3:0] OP_IRQ  = 4'h5;
  // Longer than any programmed PWM period
  localparam int SYNC_LIMIT = 4000;

  task automatic report_result(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] want, input logic ok);
    test_cnt++;
    if (ok === 1'b1)
      $display("test %0d ok: %s = %0h", test_cnt, name, got);
    else
    begin
      err_cnt++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
    end
  endtask

  task automatic note_failure(input string what);
    test_cnt++;
    err_cnt++;
    $display("test %0d failed: %s", test_cnt, what);
  endtask

  task automatic compare_read();
    int   diff;
    logic ok;
    diff = int'(PRDATA) - int'(expv);
    if (diff < 0)
      diff = -diff;
    ok = !$isunknown(PRDATA) && (diff <= int'(tol));
    report_result($sformatf("PRDATA[%02h]", sel[ADDR_W-1:0]), PRDATA, expv, ok);
    // Zero wait state slave that never signals an error
    report_result("PREADY", DATA_W'(PREADY), DATA_W'(1), PREADY === 1'b1);
    report_result("PSLVERR", DATA_W'(PSLVERR), DATA_W'(0), PSLVERR === 1'b0);
  endtask

  task automatic measure_pwm();
    int                ch;
    int                high;
    int                guard;
    logic [DATA_W-1:0] want;
    ch    = int'(sel);
    want  = expv;
    high  = 0;
    guard = 0;
    // Count from one period start to the next
    while (sync_pulse !== 1'b1 && guard < SYNC_LIMIT)
    begin
      @(negedge PCLK);
      guard++;
    end
    if (sync_pulse !== 1'b1)
      note_failure($sformatf("no period start seen for PWM[%0d]", ch));
    else
    begin
      guard = 0;
      do
      begin
        if (PWM[ch] === 1'b1)
          high++;
        @(negedge PCLK);
        guard++;
      end
      while (sync_pulse !== 1'b1 && guard < SYNC_LIMIT);
      if (sync_pulse !== 1'b1)
        note_failure($sformatf("period of PWM[%0d] never ended", ch));
      else
        report_result($sformatf("PWM[%0d] high cycles", ch), DATA_W'(high), want,
                      DATA_W'(high) == want);
    end
  endtask

  initial
  begin
    done_cnt = 0;
    test_cnt = 0;
    err_cnt  = 0;
    forever
    begin
      @(negedge PCLK);
      if (req === 1'b1)
      begin
        case (op)
          OP_READ: compare_read();
          OP_PWM:  measure_pwm();
          OP_IRQ:  report_result("TACHINT", DATA_W'(TACHINT), expv, TACHINT === expv[0]);
          default: note_failure($sformatf("unknown check request %0h", op));
        endcase
        done_cnt++;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_pwm_core.sv
// ================================================
// PWM controller testbench
// Runs register, PWM and tach operations from test data
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_core
  import pwm_pkg::*;
();

  localparam int MAX_REC    = 64;
  localparam int WAIT_LIMIT = 10000;

  localparam logic [3:0] OP_WRITE = 4'h1;
  localparam logic [3:0] OP_READ  = 4'h2;
  localparam logic [3:0] OP_PWM   = 4'h3;
  localparam logic [3:0] OP_TACH  = 4'h4;
  localparam logic [3:0] OP_IRQ   = 4'h5;
  localparam logic [3:0] OP_WAIT  = 4'h6;

  logic                PCLK = 1'b0;
  logic                PRESETN;
  logic                PSEL;
  logic                PENABLE;
  logic                PWRITE;
  logic [ADDR_W-1:0]   PADDR;
  logic [DATA_W-1:0]   PWDATA;
  logic [DATA_W-1:0]   PRDATA;
  logic                PREADY;
  logic                PSLVERR;
  logic [TACH_NUM-1:0] TACHIN;
  logic                TACHINT;
  logic [PWM_NUM-1:0]  PWM;

  // Request to the checker
  logic                req;
  logic [3:0]          req_op;
  logic [DATA_W-1:0]   req_sel;
  logic [DATA_W-1:0]   req_exp;
  logic [DATA_W-1:0]   req_tol;
  int                  done_cnt;
  int                  test_cnt;
  int                  err_cnt;
  int                  tb_err;
  logic                aborted;

  // Four words per record: op, addr, value, expect
  logic [DATA_W-1:0]   vec [0:4*MAX_REC-1];
  // Half period in PCLK cycles, 0 holds the input low
  int                  half_per [TACH_NUM] = '{default: 0};

  always #10 PCLK = ~PCLK;

  pwm_core UUT (
    .PCLK    (PCLK),
    .PRESETN (PRESETN),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR),
    .TACHIN  (TACHIN),
    .TACHINT (TACHINT),
    .PWM     (PWM)
  );

  pwm_checker u_checker (
    .PCLK       (PCLK),
    .req        (req),
    .op         (req_op),
    .sel        (req_sel),
    .expv       (req_exp),
    .tol        (req_tol),
    .PRDATA     (PRDATA),
    .PREADY     (PREADY),
    .PSLVERR    (PSLVERR),
    .PWM        (PWM),
    .TACHINT    (TACHINT),
    .sync_pulse (UUT.sync_pulse),
    .done_cnt   (done_cnt),
    .test_cnt   (test_cnt),
    .err_cnt    (err_cnt)
  );

  task automatic ask_checker(input logic [3:0] op, input logic [DATA_W-1:0] sel,
                             input logic [DATA_W-1:0] expv, input logic [DATA_W-1:0] tol);
    int start;
    int guard;
    start   = done_cnt;
    req_op  = op;
    req_sel = sel;
    req_exp = expv;
    req_tol = tol;
    req     = 1'b1;
    @(posedge PCLK);
    #2;
    req   = 1'b0;
    guard = 0;
    while (done_cnt == start && guard < WAIT_LIMIT)
    begin
      @(posedge PCLK);
      #2;
      guard++;
    end
    if (done_cnt == start)
    begin
      $display("timeout: checker gave no result for operation %0h", op);
      tb_err++;
      aborted = 1'b1;
    end
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    PSEL    = 1'b1;
    PWRITE  = 1'b1;
    PENABLE = 1'b0;
    PADDR   = addr;
    PWDATA  = data;
    @(posedge PCLK);
    #2;
    PENABLE = 1'b1;
    @(posedge PCLK);
    #2;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expv,
                          input logic [DATA_W-1:0] tol);
    PSEL    = 1'b1;
    PWRITE  = 1'b0;
    PENABLE = 1'b0;
    PADDR   = addr;
    @(posedge PCLK);
    #2;
    PENABLE = 1'b1;
    // Checker samples PRDATA in the access phase
    ask_checker(OP_READ, DATA_W'(addr), expv, tol);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  // Tach inputs, square waves
  initial
  begin
    int cnt [TACH_NUM];
    TACHIN = '0;
    cnt    = '{default: 0};
    forever
    begin
      @(posedge PCLK);
      #2;
      for (int t = 0; t < TACH_NUM; t++)
      begin
        if (half_per[t] == 0)
        begin
          TACHIN[t] = 1'b0;
          cnt[t]    = 0;
        end
        else if (cnt[t] + 1 >= half_per[t])
        begin
          TACHIN[t] = ~TACHIN[t];
          cnt[t]    = 0;
        end
        else
          cnt[t]++;
      end
    end
  end

  initial
  begin
    int                rec;
    logic [3:0]        op;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] val;
    logic [DATA_W-1:0] expv;
    PRESETN = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    req     = 1'b0;
    req_op  = '0;
    req_sel = '0;
    req_exp = '0;
    req_tol = '0;
    tb_err  = 0;
    aborted = 1'b0;
    $readmemh("pwm_tests.txt", vec);
    repeat (10) @(posedge PCLK);
    #2;
    PRESETN = 1'b1;
    rec = 0;
    while (rec < MAX_REC && vec[4*rec] != '0 && !aborted)
    begin
      op   = vec[4*rec][3:0];
      addr = vec[4*rec+1];
      val  = vec[4*rec+2];
      expv = vec[4*rec+3];
      case (op)
        OP_WRITE:       write_reg(addr[ADDR_W-1:0], val);
        OP_READ:        read_reg(addr[ADDR_W-1:0], expv, val);
        OP_PWM, OP_IRQ: ask_checker(op, addr, expv, '0);
        OP_TACH:        half_per[int'(addr)] <= int'(val);
        OP_WAIT:
        begin
          for (int i = 0; i < int'(val); i++)
          begin
            @(posedge PCLK);
            #2;
          end
        end
        default:
        begin
          tb_err++;
          $display("record %0d has an unknown operation %0h", rec, op);
        end
      endcase
      rec++;
    end
    @(posedge PCLK);
    if (test_cnt == 0)
      $display("no tests were run, the test data is missing or empty");
    $display("%0d tests, %0d errors", test_cnt, err_cnt + tb_err);
    if (test_cnt > 0 && err_cnt == 0 && tb_err == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: pwm_tests.txt
// op addr value expect, all hex; for reads the value column is the tolerance
// 1 write, 2 read, 3 PWM high cycles (addr = channel), 4 tach half period (addr = input)
// 5 TACHINT level, 6 wait cycles, 0 end
2 00 0000 0000
2 98 0000 0000
2 a4 0000 0000
1 0c 1234 0000
2 0c 0000 0000
2 c0 0000 0000
1 00 0002 0000
1 04 0009 0000
1 10 0002 0000
1 14 0006 0000
1 18 0007 0000
1 1c 0003 0000
1 20 0005 0000
1 24 0005 0000
1 28 0001 0000
1 2c 0008 0000
1 08 0007 0000
2 00 0000 0002
2 04 0000 0009
2 08 0000 0007
2 1c 0000 0003
3 00 0000 000c
3 01 0000 0012
3 02 0000 0000
3 03 0000 0000
1 94 0002 0000
2 94 0000 0002
4 00 0014 0000
6 00 00c8 0000
2 a4 0001 000a
2 98 0000 0001
5 00 0000 0000
1 9c 0001 0000
6 00 0003 0000
5 00 0000 0001
4 00 0000 0000
6 00 0032 0000
1 98 0001 0000
6 00 0003 0000
5 00 0000 0000
2 98 0000 0000
1 a0 0002 0000
2 a0 0000 0002
4 01 0010 0000
6 00 00c8 0000
2 a8 0001 0008
2 98 0000 0002
4 01 0020 0000
6 00 0190 0000
2 a8 0001 0008
1 98 0002 0000
6 00 0190 0000
2 a8 0001 0010
0 00 0000 0000

// File: pwm_core.f
pwm_pkg.sv
pwm_apb_regs.sv
pwm_timebase.sv
pwm_channels.sv
tach_capture.sv
tach_block.sv
pwm_core.sv
pwm_checker.sv
tb_pwm_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PWM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_pwm_core -f pwm_core.f -o sim_pwm
./obj_dir/sim_pwm | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
